//--- Makefile
# Verilator build and run of the ISO 14443A receive path testbench

BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module iso14443a_rx_tb \
		--Mdir $(BUILD) -f iso14443a_rx.f

# the log decides the result, and a run that stops early never prints the pass line
run: compile
	./$(BUILD)/Viso14443a_rx_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TESTS FAILED" $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/frame_decode_chk.sv
// ==============================
// frame decoder flag checker
// validates the single cycle event flags, bound to frame_decode
// ==============================

`timescale 1ns/1ps
`default_nettype none

module frame_decode_chk (
    input logic       clk,
    input logic       rst_n,
    input logic       soc,
    input logic       eoc,
    input logic       data_valid,
    input logic [2:0] data_bits,
    input logic       parity_error,
    input logic       sequence_error
);

    // ==============================
    // reset and legal combinations
    // ==============================

    // no event may leak out while the decoder is held in reset
    flags_low_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(soc || eoc || data_valid || parity_error || sequence_error))
        else $error("frame decoder flag high during reset");

    // a start of frame never shares its cycle with another event
    soc_alone: assert property (@(posedge clk) disable iff (!rst_n)
        soc |-> !(eoc || data_valid || parity_error || sequence_error))
        else $error("soc raised together with another flag");

    // a partial byte at the end of frame must say how many bits it holds
    partial_has_bits: assert property (@(posedge clk) disable iff (!rst_n)
        (data_valid && eoc) |-> (data_bits != 3'd0))
        else $error("end of frame data without a bit count");

    // a full byte inside the frame carries no bit count
    full_byte_no_bits: assert property (@(posedge clk) disable iff (!rst_n)
        (data_valid && !eoc) |-> (data_bits == 3'd0))
        else $error("full byte reported with a nonzero bit count");

    error_excludes_data: assert property (@(posedge clk) disable iff (!rst_n)
        (parity_error || sequence_error) |-> !(soc || data_valid))
        else $error("error flag raised together with soc or data");

    // ==============================
    // every flag is a one cycle pulse
    // ==============================

    soc_pulse: assert property (@(posedge clk) disable iff (!rst_n) soc |=> !soc)
        else $error("soc held for more than one cycle");
    eoc_pulse: assert property (@(posedge clk) disable iff (!rst_n) eoc |=> !eoc)
        else $error("eoc held for more than one cycle");
    data_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid |=> !data_valid)
        else $error("data_valid held for more than one cycle");
    parity_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        parity_error |=> !parity_error)
        else $error("parity_error held for more than one cycle");
    seq_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sequence_error |=> !sequence_error)
        else $error("sequence_error held for more than one cycle");

endmodule

bind frame_decode frame_decode_chk frame_decode_chk_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .soc            (soc),
    .eoc            (eoc),
    .data_valid     (data_valid),
    .data_bits      (data_bits),
    .parity_error   (parity_error),
    .sequence_error (sequence_error)
);

`default_nettype wire

//--- bench/iso14443a_rx_tb.sv
// ==============================
// ISO 14443A receive path testbench
// sends Miller coded frames, returns credits and
// checks each link event against an expected queue
// ==============================

`timescale 1ns/1ps
`default_nettype none

module iso14443a_rx_tb;

    import iso14443a_pkg::*;

    logic           clk;
    logic           rst_n;
    logic           half_valid;
    logic           half_pause;
    logic           credit_return;
    logic           ev_valid;
    rx_event_kind_t ev_kind;
    logic [7:0]     ev_data;
    logic [2:0]     ev_bits;
    logic           overflow;

    // expected events in link order, filled by the stimulus
    rx_event_kind_t exp_kind [$];
    logic [7:0]     exp_data [$];
    logic [2:0]     exp_bits [$];
    int             exp_rd        = 0;
    string          test_name     = "reset";
    logic [31:0]    lfsr          = 32'h5a64fa6b;
    logic           prev_one      = 1'b0;
    int             halves_sent   = 0;
    int             events_seen   = 0;
    int             credits_given = 0;
    int             check_errors  = 0;
    int             flow_errors   = 0;
    int             hold_start    = 0;
    bit             hold_credits  = 1'b0;
    bit             ovf_allowed   = 1'b0;
    bit             ovf_seen      = 1'b0;

    iso14443a_rx iso14443a_rx_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .half_valid    (half_valid),
        .half_pause    (half_pause),
        .credit_return (credit_return),
        .ev_valid      (ev_valid),
        .ev_kind       (ev_kind),
        .ev_data       (ev_data),
        .ev_bits       (ev_bits),
        .overflow      (overflow)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // stimulus helpers
    // ==============================

    // right shifting Galois form with taps 32, 22, 2 and 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken, first bit lands in bit 0
    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] v;
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = galois_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic [7:0] data_mask(input logic [2:0] bits);
        return (bits == 3'd0) ? 8'hFF : ((8'h01 << bits) - 8'h01);
    endfunction

    function automatic void expect_event(input rx_event_kind_t k, input logic [7:0] d,
                                         input logic [2:0] b);
        exp_kind.push_back(k);
        exp_data.push_back(d);
        exp_bits.push_back(b);
    endfunction

    // one sample with an idle cycle behind it
    task automatic half_sample(input logic p);
        @(posedge clk);
        #1;
        half_valid = 1'b1;
        half_pause = p;
        @(posedge clk);
        #1;
        half_valid = 1'b0;
        halves_sent++;
    endtask

    task automatic miller_pair(input logic first, input logic second);
        half_sample(first);
        half_sample(second);
    endtask

    // X for 1, Y for a 0 after a 1, Z for any other 0
    task automatic encode_bit(input logic b);
        if (b) begin
            miller_pair(1'b0, 1'b1);
        end else if (prev_one) begin
            miller_pair(1'b0, 1'b0);
        end else begin
            miller_pair(1'b1, 1'b0);
        end
        prev_one = b;
    endtask

    task automatic encode_bits(input logic [7:0] v, input int n);
        for (int i = 0; i < n; i++) begin
            encode_bit(v[i]);
        end
    endtask

    task automatic idle_line(input int n);
        repeat (n) miller_pair(1'b0, 1'b0);
    endtask

    // full bytes with odd parity, the last one optionally corrupted, then a tail of bits
    task automatic transmit_frame(input string name, input int nbytes, input int tail,
                                  input bit bad_par);
        logic [7:0] b;
        logic       p;
        test_name = name;
        expect_event(EV_SOC, 8'h00, 3'd0);
        miller_pair(1'b1, 1'b0);
        prev_one = 1'b0;
        for (int i = 0; i < nbytes; i++) begin
            b = random_bits(8);
            encode_bits(b, 8);
            p = ~(^b);
            if (bad_par && i == nbytes - 1) begin
                p = ~p;
                expect_event(EV_PARITY_ERR, 8'h00, 3'd0);
            end else begin
                expect_event(EV_DATA, b, 3'd0);
            end
            encode_bit(p);
        end
        if (tail == 8) begin
            b = random_bits(8);
            encode_bits(b, 8);
            expect_event(EV_EOC_PARITY, 8'h00, 3'd0);
        end else if (tail > 0) begin
            b = random_bits(tail);
            encode_bits(b, tail);
            expect_event(EV_EOC_DATA, b, 3'(tail));
        end else if (!bad_par) begin
            expect_event(EV_EOC, 8'h00, 3'd0);
        end
        // end of frame is a logic 0 followed by a Y
        encode_bit(1'b0);
        miller_pair(1'b0, 1'b0);
        idle_line(2);
    endtask

    task automatic wait_drained();
        while (exp_rd != exp_kind.size() || credits_given != events_seen) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    // ==============================
    // credit return and event checks
    // ==============================

    // each event earns its credit back two cycles later unless credits are held
    initial begin : credit_driver
        int seen_d1;
        int seen_d2;
        seen_d1 = 0;
        seen_d2 = 0;
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            seen_d2 = seen_d1;
            seen_d1 = events_seen;
            if (!hold_credits && credits_given < seen_d2) begin
                credit_return = 1'b1;
                credits_given++;
            end else begin
                credit_return = 1'b0;
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (ev_valid) begin
            events_seen++;
            assert (exp_rd < exp_kind.size()) else begin
                $display("event of kind %0d arrived while no event was expected", ev_kind);
                check_errors++;
            end
            if (exp_rd < exp_kind.size()) begin
                assert (ev_kind == exp_kind[exp_rd]) else begin
                    $display("Fail %s kind expected %0d actual %0d",
                             test_name, exp_kind[exp_rd], ev_kind);
                    check_errors++;
                end
                assert (ev_bits == exp_bits[exp_rd]) else begin
                    $display("Fail %s bits expected %0d actual %0d",
                             test_name, exp_bits[exp_rd], ev_bits);
                    check_errors++;
                end
                if (exp_kind[exp_rd] == EV_DATA || exp_kind[exp_rd] == EV_EOC_DATA) begin
                    assert ((ev_data & data_mask(exp_bits[exp_rd])) == exp_data[exp_rd])
                    else begin
                        $display("Fail %s data expected %h actual %h",
                                 test_name, exp_data[exp_rd], ev_data);
                        check_errors++;
                    end
                end
                exp_rd++;
            end
        end
        if (!ovf_allowed) begin
            assert (!overflow) else begin
                $display("Fail %s overflow expected 0 actual 1", test_name);
                check_errors++;
            end
        end
        if (ovf_seen) begin
            assert (overflow) else begin
                $display("overflow fell after it had been raised");
                check_errors++;
            end
        end
        if (overflow) begin
            ovf_seen = 1'b1;
        end
    end

    // the limit grows with the stimulus so only a stuck wait can reach it
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 40 * halves_sent + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d events still expected",
                 cycles, exp_kind.size() - exp_rd);
        $display("TESTS FAILED");
        $finish;
    end

    // ==============================
    // test sequence
    // ==============================

    initial begin : stimulus
        rst_n      = 1'b0;
        half_valid = 1'b0;
        half_pause = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // quiet link after reset, any event here has nothing to match
        test_name = "after_reset";
        repeat (20) @(posedge clk);
        idle_line(2);

        transmit_frame("standard_frame", 3, 0, 1'b0);
        wait_drained();
        transmit_frame("short_frame", 0, 7, 1'b0);
        wait_drained();
        transmit_frame("bad_parity", 2, 0, 1'b1);
        wait_drained();
        transmit_frame("open_parity", 0, 8, 1'b0);
        wait_drained();

        // pause in both halves inside a frame
        test_name = "double_pause";
        expect_event(EV_SOC, 8'h00, 3'd0);
        expect_event(EV_SEQ_ERR, 8'h00, 3'd0);
        miller_pair(1'b1, 1'b0);
        prev_one = 1'b0;
        encode_bit(1'b1);
        encode_bit(1'b0);
        miller_pair(1'b1, 1'b1);
        idle_line(2);
        wait_drained();

        // a Z right after an X can never be sent by a reader
        test_name = "z_after_x";
        expect_event(EV_SOC, 8'h00, 3'd0);
        expect_event(EV_SEQ_ERR, 8'h00, 3'd0);
        miller_pair(1'b1, 1'b0);
        prev_one = 1'b0;
        encode_bit(1'b1);
        miller_pair(1'b1, 1'b0);
        idle_line(2);
        wait_drained();
        transmit_frame("after_seq_error", 1, 0, 1'b0);
        wait_drained();

        // seven events against two credits and four FIFO entries
        hold_credits = 1'b1;
        ovf_allowed  = 1'b1;
        hold_start   = events_seen;
        transmit_frame("credit_hold", 5, 0, 1'b0);
        // the end of frame finds the FIFO full and is lost
        void'(exp_kind.pop_back());
        void'(exp_data.pop_back());
        void'(exp_bits.pop_back());
        assert (events_seen - hold_start <= RX_CREDITS) else begin
            $display("Fail credit_hold events expected %0d actual %0d",
                     RX_CREDITS, events_seen - hold_start);
            flow_errors++;
        end
        assert (overflow) else begin
            $display("Fail credit_hold overflow expected 1 actual 0");
            flow_errors++;
        end
        hold_credits = 1'b0;
        wait_drained();
        repeat (10) @(posedge clk);

        $display("closing: %0d event check errors, %0d flow check errors",
                 check_errors, flow_errors);
        if (check_errors == 0 && flow_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- iso14443a_rx.f
src/iso14443a_pkg.sv
src/miller_sequence_decode.sv
src/frame_decode.sv
src/rx_event_out.sv
src/iso14443a_rx.sv
bench/frame_decode_chk.sv
bench/iso14443a_rx_tb.sv

//--- src/frame_decode.sv
// ==============================
// ISO 14443A reader to tag frame decoder
// finds start and end of frame, assembles bytes LSB first,
// checks odd parity and reports events as one cycle flags
// ==============================

`timescale 1ns/1ps
`default_nettype none

module frame_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       seq_valid,
    input  iso14443a_pkg::miller_seq_t seq,
    output logic                       soc,
    output logic                       eoc,
    output logic                       data_valid,
    output logic [7:0]                 data,
    output logic [2:0]                 data_bits,
    output logic                       parity_error,
    output logic                       sequence_error,
    output logic                       resync
);

    import iso14443a_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_FRAME
    } state_t;

    state_t     state;
    // the last decoded bit was a 1 which means the last sequence was an X
    logic       last_one;
    // one decoded bit is held back because it may belong to the end marker
    logic       have_held;
    logic       held_bit;
    // bits committed to the current byte, 8 means the parity bit is next
    logic [3:0] bit_cnt;
    // running XOR of the committed data bits
    logic       par_q;
    // byte under assembly
    logic [7:0] byte_q;

    // per sequence decode results
    logic       bit_valid;
    logic       bit_value;
    logic       frame_end;
    logic       frame_fault;
    logic       start_frame;
    logic       idle_fault;
    logic       commit;
    logic       parity_slot;
    logic       parity_ok;

    // ==============================
    // sequence to bit decode
    // ==============================

    always_comb begin
        bit_valid   = 1'b0;
        bit_value   = 1'b0;
        frame_end   = 1'b0;
        frame_fault = 1'b0;
        if (seq_valid && (state == ST_FRAME)) begin
            unique case (seq)
                SEQ_X: begin
                    bit_valid = 1'b1;
                    bit_value = 1'b1;
                end
                SEQ_Z: begin
                    // a 0 after a 1 must be sent as Y so Z here is illegal
                    if (last_one) begin
                        frame_fault = 1'b1;
                    end else begin
                        bit_valid = 1'b1;
                    end
                end
                SEQ_Y: begin
                    // Y after a 0 or straight after soc is the end of frame marker
                    if (last_one) begin
                        bit_valid = 1'b1;
                    end else begin
                        frame_end = 1'b1;
                    end
                end
                SEQ_ERR: begin
                    frame_fault = 1'b1;
                end
            endcase
        end
    end

    assign start_frame = seq_valid && (state == ST_IDLE) && (seq == SEQ_Z);
    // a pause in both halves is never legal on the line, in or out of a frame
    assign idle_fault  = seq_valid && (state == ST_IDLE) && (seq == SEQ_ERR);
    // an idle line carries Y, so it marks where a bit period really begins
    assign resync      = seq_valid && (state == ST_IDLE) && (seq == SEQ_Y);

    // a new bit pushes the held one into the byte
    assign commit      = bit_valid && have_held;
    assign parity_slot = (bit_cnt == 4'd8);
    // odd parity means data ones plus the parity bit give an odd count
    assign parity_ok   = par_q ^ held_bit;

    // ==============================
    // frame control and event flags
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            last_one       <= 1'b0;
            have_held      <= 1'b0;
            bit_cnt        <= 4'd0;
            par_q          <= 1'b0;
            soc            <= 1'b0;
            eoc            <= 1'b0;
            data_valid     <= 1'b0;
            data_bits      <= 3'd0;
            parity_error   <= 1'b0;
            sequence_error <= 1'b0;
        end else begin
            // every flag is a single cycle pulse
            soc            <= 1'b0;
            eoc            <= 1'b0;
            data_valid     <= 1'b0;
            data_bits      <= 3'd0;
            parity_error   <= 1'b0;
            sequence_error <= 1'b0;

            if (start_frame) begin
                state     <= ST_FRAME;
                soc       <= 1'b1;
                last_one  <= 1'b0;
                have_held <= 1'b0;
                bit_cnt   <= 4'd0;
                par_q     <= 1'b0;
            end

            if (frame_fault || idle_fault) begin
                sequence_error <= 1'b1;
                state          <= ST_IDLE;
            end

            if (bit_valid) begin
                last_one  <= bit_value;
                have_held <= 1'b1;
            end

            if (commit) begin
                if (!parity_slot) begin
                    bit_cnt <= bit_cnt + 4'd1;
                    par_q   <= par_q ^ held_bit;
                end else if (parity_ok) begin
                    data_valid <= 1'b1;
                    bit_cnt    <= 4'd0;
                    par_q      <= 1'b0;
                end else begin
                    parity_error <= 1'b1;
                    state        <= ST_IDLE;
                end
            end

            // the held 0 was part of the end marker and is dropped here
            if (frame_end) begin
                eoc   <= 1'b1;
                state <= ST_IDLE;
                if (parity_slot) begin
                    parity_error <= 1'b1;
                end else if (bit_cnt != 4'd0) begin
                    data_valid <= 1'b1;
                    data_bits  <= bit_cnt[2:0];
                end
            end
        end
    end

    // byte assembly and the output byte
    always_ff @(posedge clk) begin
        if (bit_valid) begin
            held_bit <= bit_value;
        end
        // cleared at each byte start so a partial byte has zero upper bits
        if (start_frame) begin
            byte_q <= 8'h00;
        end
        if (commit && !parity_slot) begin
            byte_q[bit_cnt[2:0]] <= held_bit;
        end
        if (commit && parity_slot) begin
            data   <= byte_q;
            byte_q <= 8'h00;
        end
        if (frame_end) begin
            data <= byte_q;
        end
    end

endmodule

`default_nettype wire

//--- src/iso14443a_pkg.sv
// ==============================
// iso14443a receive path definitions
// modified Miller sequence codes, event kinds
// and the sizing of the event FIFO and credit link
// ==============================

`default_nettype none

package iso14443a_pkg;

    // one sequence per bit period, built from the first and second half pause samples
    // the code is simply {first_half_pause, second_half_pause}
    typedef enum logic [1:0] {
        SEQ_Y   = 2'b00,
        SEQ_X   = 2'b01,
        SEQ_Z   = 2'b10,
        SEQ_ERR = 2'b11
    } miller_seq_t;

    // what the frame decoder reported in one cycle, as carried on the event link
    typedef enum logic [2:0] {
        EV_SOC        = 3'd0,
        EV_DATA       = 3'd1,
        EV_EOC        = 3'd2,
        EV_EOC_DATA   = 3'd3,
        EV_EOC_PARITY = 3'd4,
        EV_PARITY_ERR = 3'd5,
        EV_SEQ_ERR    = 3'd6
    } rx_event_kind_t;

    // event FIFO entries between the frame decoder and the link
    localparam int RX_FIFO_DEPTH = 4;

    // credits the downstream receiver grants us after reset
    localparam int RX_CREDITS = 2;

    // widths derived from the sizes above
    localparam int RX_FIFO_AW  = $clog2(RX_FIFO_DEPTH);
    localparam int RX_CNT_W    = $clog2(RX_FIFO_DEPTH + 1);
    localparam int RX_CREDIT_W = $clog2(RX_CREDITS + 1);

endpackage

`default_nettype wire

//--- src/iso14443a_rx.sv
// ==============================
// ISO 14443A receive path top level
// half samples in, credit controlled frame events out
// ==============================

`timescale 1ns/1ps
`default_nettype none

module iso14443a_rx (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          half_valid,
    input  logic                          half_pause,
    input  logic                          credit_return,
    output logic                          ev_valid,
    output iso14443a_pkg::rx_event_kind_t ev_kind,
    output logic [7:0]                    ev_data,
    output logic [2:0]                    ev_bits,
    output logic                          overflow
);

    import iso14443a_pkg::*;

    // sequence stream between the Miller decoder and the frame decoder
    logic        seq_valid;
    miller_seq_t seq;
    // idle line seen by the frame decoder realigns the half phase
    logic        resync;

    // frame decoder flags
    logic        soc;
    logic        eoc;
    logic        data_valid;
    logic [7:0]  data;
    logic [2:0]  data_bits;
    logic        parity_error;
    logic        sequence_error;

    miller_sequence_decode u_seq_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .half_valid (half_valid),
        .half_pause (half_pause),
        .resync     (resync),
        .seq_valid  (seq_valid),
        .seq        (seq)
    );

    frame_decode u_frame_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .seq_valid      (seq_valid),
        .seq            (seq),
        .soc            (soc),
        .eoc            (eoc),
        .data_valid     (data_valid),
        .data           (data),
        .data_bits      (data_bits),
        .parity_error   (parity_error),
        .sequence_error (sequence_error),
        .resync         (resync)
    );

    rx_event_out u_event_out (
        .clk            (clk),
        .rst_n          (rst_n),
        .soc            (soc),
        .eoc            (eoc),
        .data_valid     (data_valid),
        .data           (data),
        .data_bits      (data_bits),
        .parity_error   (parity_error),
        .sequence_error (sequence_error),
        .credit_return  (credit_return),
        .ev_valid       (ev_valid),
        .ev_kind        (ev_kind),
        .ev_data        (ev_data),
        .ev_bits        (ev_bits),
        .overflow       (overflow)
    );

endmodule

`default_nettype wire

//--- src/miller_sequence_decode.sv
// ==============================
// modified Miller sequence decoder
// pairs half-bit pause samples into X, Y, Z sequences
// and marks a pause in both halves as illegal
// ==============================

`timescale 1ns/1ps
`default_nettype none

module miller_sequence_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       half_valid,
    input  logic                       half_pause,
    input  logic                       resync,
    output logic                       seq_valid,
    output iso14443a_pkg::miller_seq_t seq
);

    import iso14443a_pkg::*;

    // high while the next accepted sample is the second half of a bit period
    logic        second_half;
    // pause sample captured in the first half
    logic        first_pause;
    // this sample closes a pair
    logic        take_second;
    // sequence formed by the stored first half and the current sample
    miller_seq_t pair_seq;

    // a resync in the same cycle as a sample pulls that sample back to a first half
    assign take_second = half_valid && second_half && !resync;

    always_comb begin
        case ({first_pause, half_pause})
            2'b00:   pair_seq = SEQ_Y;
            2'b01:   pair_seq = SEQ_X;
            2'b10:   pair_seq = SEQ_Z;
            default: pair_seq = SEQ_ERR;
        endcase
    end

    // ==============================
    // half phase and output strobe
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            second_half <= 1'b0;
            seq_valid   <= 1'b0;
        end else begin
            // the sequence appears one cycle after its second half
            seq_valid <= take_second;

            if (take_second) begin
                second_half <= 1'b0;
            end else if (half_valid) begin
                // every other accepted sample opens a new bit period
                second_half <= 1'b1;
            end else if (resync) begin
                second_half <= 1'b0;
            end
        end
    end

    // sample storage and the decoded sequence itself
    always_ff @(posedge clk) begin
        if (half_valid && !take_second) begin
            first_pause <= half_pause;
        end
        if (take_second) begin
            seq <= pair_seq;
        end
    end

endmodule

`default_nettype wire

//--- src/rx_event_out.sv
// ==============================
// receive event output stage
// queues frame decoder events in a small FIFO and
// sends them downstream under credit based flow control
// ==============================

`timescale 1ns/1ps
`default_nettype none

module rx_event_out (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          soc,
    input  logic                          eoc,
    input  logic                          data_valid,
    input  logic [7:0]                    data,
    input  logic [2:0]                    data_bits,
    input  logic                          parity_error,
    input  logic                          sequence_error,
    input  logic                          credit_return,
    output logic                          ev_valid,
    output iso14443a_pkg::rx_event_kind_t ev_kind,
    output logic [7:0]                    ev_data,
    output logic [2:0]                    ev_bits,
    output logic                          overflow
);

    import iso14443a_pkg::*;

    rx_event_kind_t              kind_mem [RX_FIFO_DEPTH];
    logic [7:0]                  data_mem [RX_FIFO_DEPTH];
    logic [2:0]                  bits_mem [RX_FIFO_DEPTH];

    logic [RX_FIFO_AW-1:0]       wr_ptr;
    logic [RX_FIFO_AW-1:0]       rd_ptr;
    logic [RX_CNT_W-1:0]         fill;
    logic [RX_CREDIT_W-1:0]      credits;

    rx_event_kind_t              push_kind;
    logic                        any_flag;
    logic                        fifo_full;
    logic                        push;
    logic                        pop;

    function automatic logic [RX_FIFO_AW-1:0] next_ptr(input logic [RX_FIFO_AW-1:0] p);
        next_ptr = (p == RX_FIFO_AW'(RX_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ==============================
    // flag to event kind mapping
    // ==============================

    // errors win since they may come together with eoc
    always_comb begin
        if (sequence_error) begin
            push_kind = EV_SEQ_ERR;
        end else if (parity_error && eoc) begin
            push_kind = EV_EOC_PARITY;
        end else if (parity_error) begin
            push_kind = EV_PARITY_ERR;
        end else if (eoc && data_valid) begin
            push_kind = EV_EOC_DATA;
        end else if (eoc) begin
            push_kind = EV_EOC;
        end else if (data_valid) begin
            push_kind = EV_DATA;
        end else begin
            push_kind = EV_SOC;
        end
    end

    assign any_flag  = soc | eoc | data_valid | parity_error | sequence_error;
    assign fifo_full = (fill == RX_CNT_W'(RX_FIFO_DEPTH));
    // the head leaves only while the receiver still has room for it
    assign pop       = (fill != '0) && (credits != '0);
    // a full FIFO still takes the event when the head leaves in the same cycle
    assign push      = any_flag && (!fifo_full || pop);

    // ==============================
    // FIFO control, credits and overflow
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            credits  <= RX_CREDIT_W'(RX_CREDITS);
            ev_valid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            ev_valid <= pop;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
            // a returned credit in a send cycle cancels the credit spent
            if (pop && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (credit_return && !pop) begin
                credits <= credits + 1'b1;
            end
            // sticky once any event has been lost
            if (any_flag && !push) begin
                overflow <= 1'b1;
            end
        end
    end

    // entry storage and the link payload
    always_ff @(posedge clk) begin
        if (push) begin
            kind_mem[wr_ptr] <= push_kind;
            data_mem[wr_ptr] <= data;
            bits_mem[wr_ptr] <= data_bits;
        end
        if (pop) begin
            ev_kind <= kind_mem[rd_ptr];
            ev_data <= data_mem[rd_ptr];
            ev_bits <= bits_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire
